/* sim.f */
hdl/uart_cfg_pkg.sv
hdl/uart_tx_pkg.sv
hdl/baud_tick_gen.sv
hdl/transmitter_controller.sv
hdl/piso.sv
hdl/uart_transmitter.sv
hdl/uart_tx_top.sv
verification/tb_clock_gen.sv
verification/uart_tx_tb.sv

/* verification/uart_tx_tb.sv */
`timescale 1ns/1ps

module uart_tx_tb;
    import uart_cfg_pkg::*;
    import uart_tx_pkg::*;

    localparam int BAUD_DIV        = 4;
    localparam int FRAME_SLOTS     = 24;
    localparam int FRAME_CLK_LIMIT = 2 * MAX_FRAME_BITS * BAUD_DIV;
    localparam int WATCHDOG_NS     = 2 * FRAME_SLOTS * MAX_FRAME_BITS * BAUD_DIV * 40;

    logic                  clk;
    logic                  reset_n;
    logic [BAUD_DIV_W-1:0] baud_div;
    logic                  tx_en;
    logic                  start_tx;
    logic [DATA_W-1:0]     data;
    data_len_e             data_bit_num;
    logic                  parity_en;
    parity_e               parity_type;
    logic                  stop_bit_num;
    logic                  cts_n;
    logic                  tx_o;
    logic                  tx_busy;
    logic                  trans_fi;

    logic [15:0] lfsr_q;
    int          errors          = 0;
    int          expected_frames = 0;
    int          expected_aborts = 0;
    int          finish_count    = 0;
    int          frames_checked  = 0;
    int          frames_aborted  = 0;

    tb_clock_gen i_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    uart_tx_top i_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .baud_div_i     (baud_div),
        .tx_en_i        (tx_en),
        .start_tx_i     (start_tx),
        .data_i         (data),
        .data_bit_num_i (data_bit_num),
        .parity_en_i    (parity_en),
        .parity_type_i  (parity_type),
        .stop_bit_num_i (stop_bit_num),
        .cts_ni         (cts_n),
        .tx_o           (tx_o),
        .tx_busy_o      (tx_busy),
        .trans_fi_o     (trans_fi)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // Bits on the line in order: start, data LSB first, parity, then stop level.
    function automatic logic [MAX_FRAME_BITS-1:0] expected_frame(
        input logic [DATA_W-1:0] value,
        input logic [1:0]        len_code,
        input logic              par_en,
        input logic              par_odd
    );
        logic [MAX_FRAME_BITS-1:0] bits;
        int                        n_data;
        logic                      par;
        bits   = '1;
        n_data = 5 + len_code;
        par    = par_odd;
        bits[0] = 1'b0;
        for (int i = 0; i < n_data; i++) begin
            bits[1 + i] = value[i];
            par = par ^ value[i];
        end
        if (par_en) begin
            bits[1 + n_data] = par;
        end
        return bits;
    endfunction

    function automatic int frame_length(input logic [1:0] len_code, input logic par_en,
                                        input logic stop2);
        return 1 + 5 + len_code + par_en + 1 + stop2;
    endfunction

    task automatic take_random(input int nbits, output logic [DATA_W-1:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_finish();
        int n;
        n = 0;
        while (!trans_fi && n < FRAME_CLK_LIMIT) begin
            step();
            n++;
        end
        if (!trans_fi) begin
            errors++;
            $display("No finish pulse arrived within %0d clocks of the start", FRAME_CLK_LIMIT);
        end
    endtask

    // With disturb set, a second start and a cts_n rise hit the frame in flight.
    task automatic send_frame(input logic [1:0] len_code, input logic par_en,
                              input logic par_odd, input logic stop2, input logic disturb);
        logic [DATA_W-1:0] value;
        take_random(DATA_W, value);
        data         = value;
        data_bit_num = data_len_e'(len_code);
        parity_en    = par_en;
        parity_type  = parity_e'(par_odd);
        stop_bit_num = stop2;
        start_tx     = 1'b1;
        step();
        start_tx = 1'b0;
        expected_frames++;
        if (disturb) begin
            repeat (10) step();
            start_tx = 1'b1;
            step();
            start_tx = 1'b0;
            cts_n    = 1'b1;
        end
        wait_finish();
        cts_n = 1'b0;
        step();
    endtask

    task automatic blocked_start(input logic cts_val, input logic en_val);
        cts_n = cts_val;
        tx_en = en_val;
        step();
        start_tx = 1'b1;
        step();
        start_tx = 1'b0;
        repeat (MAX_FRAME_BITS * BAUD_DIV) step();
        cts_n = 1'b0;
        tx_en = 1'b1;
        step();
    endtask

    task automatic abort_frame();
        logic [DATA_W-1:0] value;
        take_random(DATA_W, value);
        data         = value;
        data_bit_num = LEN8;
        parity_en    = 1'b1;
        parity_type  = PAR_ODD;
        stop_bit_num = 1'b1;
        start_tx     = 1'b1;
        step();
        start_tx = 1'b0;
        expected_aborts++;
        repeat (5 * BAUD_DIV) step();
        tx_en = 1'b0;
        repeat (2 * BAUD_DIV) step();
        tx_en = 1'b1;
        step();
    endtask

    // Finds the falling start edge and checks every bit at mid-bit.
    initial begin : line_monitor
        logic                      prev;
        logic [MAX_FRAME_BITS-1:0] bits;
        int                        n_bits;
        logic                      aborted;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (reset_n && prev && !tx_o) begin
                bits    = expected_frame(data, data_bit_num, parity_en, parity_type);
                n_bits  = frame_length(data_bit_num, parity_en, stop_bit_num);
                aborted = 1'b0;
                repeat (2) @(negedge clk);
                for (int k = 0; k < n_bits; k++) begin
                    if (k > 0) begin
                        repeat (BAUD_DIV) @(negedge clk);
                    end
                    if (!tx_en) begin
                        aborted = 1'b1;
                        break;
                    end
                    if (tx_o !== bits[k]) begin
                        errors++;
                        $display("Fail: tx_o frame bit %0d expected %h got %h", k, bits[k], tx_o);
                    end
                end
                if (aborted) begin
                    frames_aborted++;
                end else begin
                    frames_checked++;
                    // The last stop bit ends 1.5 clocks after its sample, and the finish
                    // pulse follows one clock after that.
                    repeat (3) @(negedge clk);
                    if (trans_fi !== 1'b1) begin
                        errors++;
                        $display("Fail: trans_fi_o at frame end expected %h got %h",
                                 1'b1, trans_fi);
                    end
                end
            end
            prev = tx_o;
        end
    end

    always @(negedge clk) begin
        if (reset_n && trans_fi) begin
            finish_count++;
        end
    end

    a_finish_single: assert property (@(posedge clk) disable iff (!reset_n)
        trans_fi |=> !trans_fi)
        else begin
            errors++;
            $display("trans_fi_o stayed high for more than one clock");
        end

    a_busy_after_finish: assert property (@(posedge clk) disable iff (!reset_n)
        trans_fi |-> tx_busy ##1 !tx_busy)
        else begin
            errors++;
            $display("tx_busy_o did not fall right after the finish pulse");
        end

    a_idle_line: assert property (@(posedge clk) disable iff (!reset_n)
        !tx_busy |-> (tx_o && !trans_fi))
        else begin
            errors++;
            $display("Line was not idle high, or a finish pulse came while not busy");
        end

    a_busy_needs_start: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(tx_busy) |-> $past(start_tx && tx_en && !cts_n))
        else begin
            errors++;
            $display("Transmitter went busy without a qualified start pulse");
        end

    a_start_ignored: assert property (@(posedge clk) disable iff (!reset_n)
        (start_tx && !tx_busy && (cts_n || !tx_en)) |=> !tx_busy)
        else begin
            errors++;
            $display("A start pulse was taken while cts_ni was high or tx_en_i was low");
        end

    a_start_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
        (start_tx && tx_busy && tx_en && !trans_fi) |=> tx_busy)
        else begin
            errors++;
            $display("A start pulse during a frame disturbed the frame");
        end

    a_abort: assert property (@(posedge clk) disable iff (!reset_n)
        (tx_busy && !tx_en && !trans_fi) |=> (!tx_busy && tx_o && !trans_fi))
        else begin
            errors++;
            $display("Dropping tx_en_i did not return the line to idle at the next clock");
        end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        baud_div     = BAUD_DIV_W'(BAUD_DIV);
        tx_en        = 1'b1;
        start_tx     = 1'b0;
        data         = '0;
        data_bit_num = LEN8;
        parity_en    = 1'b0;
        parity_type  = PAR_EVEN;
        stop_bit_num = 1'b0;
        cts_n        = 1'b0;
        lfsr_q       = 16'd46;
        @(posedge reset_n);
        repeat (3) step();
        for (int len = 0; len < 4; len++) begin
            repeat (2) send_frame(len[1:0], 1'b0, 1'b0, 1'b0, 1'b0);
        end
        for (int len = 0; len < 4; len++) begin
            send_frame(len[1:0], 1'b1, 1'b0, len[0], 1'b0);
            send_frame(len[1:0], 1'b1, 1'b1, ~len[0], 1'b0);
        end
        blocked_start(1'b1, 1'b1);
        blocked_start(1'b0, 1'b0);
        send_frame(2'd1, 1'b1, 1'b0, 1'b1, 1'b1);
        abort_frame();
        send_frame(2'd3, 1'b1, 1'b1, 1'b1, 1'b0);
        send_frame(2'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (4) step();
        if (finish_count != expected_frames) begin
            errors++;
            $display("Fail: trans_fi_o pulse count expected %h got %h",
                     expected_frames, finish_count);
        end
        if (frames_checked != expected_frames) begin
            errors++;
            $display("Fail: tx_o frame count expected %h got %h", expected_frames, frames_checked);
        end
        if (frames_aborted != expected_aborts) begin
            errors++;
            $display("Fail: tx_o aborted frame count expected %h got %h",
                     expected_aborts, frames_aborted);
        end
        $display("Frames %0d, finish pulses %0d, aborted frames %0d, errors %0d",
                 frames_checked, finish_count, frames_aborted, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);
    localparam int CLK_HALF_NS  = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #(CLK_HALF_NS) clk_o = ~clk_o;
    end

    // Reset is released just after an edge, like the rest of the stimulus.
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        reset_n_o = 1'b1;
    end

endmodule

/* hdl/uart_tx_top.sv */
`timescale 1ns/1ps

module uart_tx_top (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic [uart_tx_pkg::BAUD_DIV_W-1:0] baud_div_i,
    input  logic                               tx_en_i,
    input  logic                               start_tx_i,
    input  logic [uart_cfg_pkg::DATA_W-1:0]   data_i,
    input  uart_cfg_pkg::data_len_e            data_bit_num_i,
    input  logic                               parity_en_i,
    input  uart_cfg_pkg::parity_e              parity_type_i,
    input  logic                               stop_bit_num_i,
    input  logic                               cts_ni,
    output logic                               tx_o,
    output logic                               tx_busy_o,
    output logic                               trans_fi_o
);

    logic tick;

    // The bit clock runs only while the transmitter is enabled.
    baud_tick_gen i_baud_tick_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable_i   (tx_en_i),
        .baud_div_i (baud_div_i),
        .tick_o     (tick)
    );

    uart_transmitter i_uart_transmitter (
        .clk            (clk),
        .reset_n        (reset_n),
        .tick_i         (tick),
        .tx_en_i        (tx_en_i),
        .start_tx_i     (start_tx_i),
        .cts_ni         (cts_ni),
        .parity_en_i    (parity_en_i),
        .parity_type_i  (parity_type_i),
        .stop_bit_num_i (stop_bit_num_i),
        .data_bit_num_i (data_bit_num_i),
        .data_i         (data_i),
        .tx_o           (tx_o),
        .tx_busy_o      (tx_busy_o),
        .trans_fi_o     (trans_fi_o)
    );

endmodule

/* hdl/uart_transmitter.sv */
`timescale 1ns/1ps

module uart_transmitter (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             tick_i,
    input  logic                             tx_en_i,
    input  logic                             start_tx_i,
    input  logic                             cts_ni,
    input  logic                             parity_en_i,
    input  uart_cfg_pkg::parity_e            parity_type_i,
    input  logic                             stop_bit_num_i,
    input  uart_cfg_pkg::data_len_e          data_bit_num_i,
    input  logic [uart_cfg_pkg::DATA_W-1:0] data_i,
    output logic                             tx_o,
    output logic                             tx_busy_o,
    output logic                             trans_fi_o
);
    import uart_cfg_pkg::*;
    import uart_tx_pkg::*;

    logic [DATA_W-1:0] data_mask;
    logic [DATA_W-1:0] data_pad;
    logic [CNT_W-1:0]  data_size;
    logic [CNT_W-1:0]  stop_bit_size;
    logic [CNT_W-1:0]  total_data;
    logic [CNT_W-1:0]  cnt_data_trans;
    logic              parity_bit;
    logic              trans_en;
    logic              shift_en;
    logic              tick_d;
    logic              load_en;
    logic              load_d0;
    logic              trans_data_fi;
    logic              trans_stop_fi;

    assign data_size     = CNT_W'(MIN_DATA_BITS) + CNT_W'(data_bit_num_i);
    assign stop_bit_size = stop_bit_num_i ? CNT_W'(MAX_STOP_BITS) : CNT_W'(1);
    assign total_data    = CNT_W'(START_BITS) + data_size + CNT_W'(parity_en_i) + stop_bit_size;

    // Bits above the selected length become ones and go out as stop level.
    assign data_mask = ~({DATA_W{1'b1}} << data_size);
    assign data_pad  = data_i | ~data_mask;

    // Even parity makes the total XOR zero, odd parity inverts it.
    assign parity_bit = (^(data_i & data_mask)) ^ (parity_type_i == PAR_ODD);

    assign shift_en = trans_en && tick_i;

    // Count n is the slot whose bit the next tick places on the line.
    // The count parks on the frame length until the closing tick has been seen.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_data_trans <= '0;
        end else if (!trans_en) begin
            cnt_data_trans <= '0;
        end else if (shift_en && !trans_stop_fi) begin
            cnt_data_trans <= cnt_data_trans + CNT_W'(1);
        end
    end

    assign trans_data_fi = (cnt_data_trans == data_size + CNT_W'(START_BITS));
    assign trans_stop_fi = (cnt_data_trans == total_data);

    // The tick that closes the last stop bit, one clock late.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tick_d <= 1'b0;
        end else begin
            tick_d <= shift_en && trans_stop_fi;
        end
    end

    // Zero for the start slot, and for the parity slot when parity comes out low.
    assign load_d0 = (cnt_data_trans == '0) || (parity_en_i && !parity_bit && trans_data_fi);

    // Outside a frame the shift register keeps taking the padded character.
    assign load_en = !trans_en;

    transmitter_controller i_transmitter_controller (
        .clk             (clk),
        .reset_n         (reset_n),
        .tx_en_i         (tx_en_i),
        .start_tx_i      (start_tx_i),
        .cts_ni          (cts_ni),
        .trans_stop_fi_i (trans_stop_fi),
        .tick_d_i        (tick_d),
        .trans_en_o      (trans_en),
        .tx_busy_o       (tx_busy_o),
        .tx_finish_o     (trans_fi_o)
    );

    piso i_piso (
        .clk        (clk),
        .reset_n    (reset_n),
        .shift_en_i (shift_en),
        .load_en_i  (load_en),
        .load_d0_i  (load_d0),
        .data_i     (data_pad),
        .tx_o       (tx_o)
    );

    // The count stays within the longest legal frame for every format.
    assert property (@(posedge clk) disable iff (!reset_n)
        cnt_data_trans <= CNT_W'(MAX_FRAME_BITS));

endmodule

/* hdl/piso.sv */
`timescale 1ns/1ps

module piso (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             shift_en_i,
    input  logic                             load_en_i,
    input  logic                             load_d0_i,
    input  logic [uart_cfg_pkg::DATA_W-1:0] data_i,
    output logic                             tx_o
);
    import uart_cfg_pkg::*;

    logic [DATA_W-1:0] shift_q;
    logic              line_busy_q;

    // Ones shift in from the top, so the line rests high after the last data bit.
    always_ff @(posedge clk) begin
        if (load_en_i) begin
            shift_q <= data_i;
        end else if (shift_en_i && !load_d0_i) begin
            shift_q <= {1'b1, shift_q[DATA_W-1:1]};
        end
    end

    // A shift with load_d0_i drives a zero and holds the character in place.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_o <= 1'b1;
        end else if (load_en_i) begin
            tx_o <= 1'b1;
        end else if (shift_en_i) begin
            tx_o <= load_d0_i ? 1'b0 : shift_q[0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            line_busy_q <= 1'b0;
        end else if (load_en_i) begin
            line_busy_q <= 1'b0;
        end else if (shift_en_i) begin
            line_busy_q <= 1'b1;
        end
    end

    // Until the first shift of a frame the line must stay at the idle level.
    assert property (@(posedge clk) disable iff (!reset_n)
        !line_busy_q |-> tx_o);

endmodule

/* hdl/transmitter_controller.sv */
`timescale 1ns/1ps

module transmitter_controller (
    input  logic clk,
    input  logic reset_n,
    input  logic tx_en_i,
    input  logic start_tx_i,
    input  logic cts_ni,
    input  logic trans_stop_fi_i,
    input  logic tick_d_i,
    output logic trans_en_o,
    output logic tx_busy_o,
    output logic tx_finish_o
);
    import uart_tx_pkg::*;

    tx_state_e state_q;
    tx_state_e state_d;
    logic      start_ok;

    // A start pulse counts only with the link enabled and the far end ready.
    assign start_ok = start_tx_i && tx_en_i && !cts_ni;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            TX_IDLE: begin
                if (start_ok) begin
                    state_d = TX_SEND;
                end
            end
            TX_SEND: begin
                // Losing the enable abandons the frame without a finish pulse.
                if (!tx_en_i) begin
                    state_d = TX_IDLE;
                end else if (trans_stop_fi_i && tick_d_i) begin
                    state_d = TX_FINISH;
                end
            end
            TX_FINISH: begin
                state_d = TX_IDLE;
            end
            default: begin
                state_d = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= TX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // The enable is gated so that an abort stops the line at the very next clock.
    assign trans_en_o  = (state_q == TX_SEND) && tx_en_i;
    assign tx_busy_o   = (state_q != TX_IDLE);
    assign tx_finish_o = (state_q == TX_FINISH);

    // The finish pulse lasts a single clock.
    assert property (@(posedge clk) disable iff (!reset_n)
        tx_finish_o |=> !tx_finish_o);

    // Transmission only begins from idle after a start that passed all qualifiers.
    assert property (@(posedge clk) disable iff (!reset_n)
        $rose(trans_en_o) |-> $past(state_q == TX_IDLE && start_ok));

endmodule

/* hdl/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               enable_i,
    input  logic [uart_tx_pkg::BAUD_DIV_W-1:0] baud_div_i,
    output logic                               tick_o
);
    import uart_tx_pkg::*;

    logic [BAUD_DIV_W-1:0] div_cnt_q;
    logic                  expire;

    // A divider of 0 or 1 expires on every clock.
    assign expire = (div_cnt_q <= BAUD_DIV_W'(1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt_q <= '0;
            tick_o    <= 1'b0;
        end else if (!enable_i) begin
            // Parked at the reload value so the first period after enabling is complete.
            div_cnt_q <= baud_div_i;
            tick_o    <= 1'b0;
        end else if (expire) begin
            div_cnt_q <= baud_div_i;
            tick_o    <= 1'b1;
        end else begin
            div_cnt_q <= div_cnt_q - BAUD_DIV_W'(1);
            tick_o    <= 1'b0;
        end
    end

endmodule

/* hdl/uart_tx_pkg.sv */
package uart_tx_pkg;

    // Transmit controller states.
    typedef enum logic [1:0] {
        TX_IDLE   = 2'b00,
        TX_SEND   = 2'b01,
        TX_FINISH = 2'b10
    } tx_state_e;

    // Bit counter width. It must hold the longest frame length.
    localparam int unsigned CNT_W = 4;

    // Width of the baud divider value and of its down-counter.
    localparam int unsigned BAUD_DIV_W = 16;

endpackage

/* hdl/uart_cfg_pkg.sv */
package uart_cfg_pkg;

    // Width of the character input. Shorter characters use the low bits.
    localparam int unsigned DATA_W = 8;

    // Character length select, as driven on data_bit_num_i.
    typedef enum logic [1:0] {
        LEN5 = 2'b00,
        LEN6 = 2'b01,
        LEN7 = 2'b10,
        LEN8 = 2'b11
    } data_len_e;

    // Parity sense, as driven on parity_type_i.
    typedef enum logic {
        PAR_EVEN = 1'b0,
        PAR_ODD  = 1'b1
    } parity_e;

    // The length code counts up from the shortest character.
    localparam int unsigned MIN_DATA_BITS = 5;
    localparam int unsigned START_BITS    = 1;
    localparam int unsigned MAX_STOP_BITS = 2;

    // Longest frame on the line: start, full character, parity and two stops.
    localparam int unsigned MAX_FRAME_BITS = START_BITS + DATA_W + 1 + MAX_STOP_BITS;

endpackage
